/* hw/wh_link_pkg.sv */
// ral to wormhole link package
// widths, packet layout and link types shared by both directions of the bridge
// one packet is a header flit followed by the data word split into flits

package wh_link_pkg;

  // ral word and wormhole flit widths
  localparam int ral_data_width = 32;
  localparam int flit_width     = 16;

  // header field widths
  localparam int cord_width = 6;
  localparam int len_width  = 3;

  // every packet is exactly three flits
  localparam int flit_count = 3;
  // length field counts the flits after the header
  localparam logic [len_width-1:0] pkt_len = len_width'(flit_count - 1);
  // wide enough to count a full packet
  localparam int flit_cnt_width = $clog2(flit_count + 1);

  // 7 zero bits above the data word
  localparam int pkt_pad_width = flit_count*flit_width - ral_data_width
                                 - len_width - cord_width;

  // eight entries per async fifo
  localparam int fifo_lg_depth = 3;

  // header with cord in the low bits
  typedef struct packed {
    logic [len_width-1:0]  len;
    logic [cord_width-1:0] cord;
  } wh_hdr_s;

  // packet as fields with the header at the lsb end
  typedef struct packed {
    logic [pkt_pad_width-1:0]  pad;
    logic [ral_data_width-1:0] data;
    wh_hdr_s                   hdr;
  } wh_pkt_s;

  // same packet seen as flits, flit 0 goes out first
  typedef union packed {
    wh_pkt_s                               pkt;
    logic [flit_count-1:0][flit_width-1:0] flits;
  } wh_pkt_u;

  // ral side link
  typedef struct packed {
    logic                      v;
    logic [ral_data_width-1:0] data;
  } ral_link_s;

  // wormhole side link
  typedef struct packed {
    logic                  v;
    logic [flit_width-1:0] data;
  } wh_link_s;

endpackage

/* hw/flit_serializer.sv */
`timescale 1ns/1ns
// flit serializer
// builds a wormhole packet from one ral word and its destination
// and sends its three flits in order, stalling while the fifo is full

module flit_serializer
  (input  logic                                   clk_i
  ,input  logic                                   rst_i
  ,input  logic                                   in_v_i
  ,input  logic [wh_link_pkg::ral_data_width-1:0] in_data_i
  ,input  logic [wh_link_pkg::cord_width-1:0]     in_cord_i
  ,output logic                                   in_ready_o
  ,output logic                                   out_v_o
  ,output logic [wh_link_pkg::flit_width-1:0]     out_flit_o
  ,input  logic                                   out_full_i
  );

  import wh_link_pkg::*;

  wh_pkt_u                   pkt_n;
  wh_pkt_u                   pkt_r;
  logic                      busy_r;
  logic [flit_cnt_width-1:0] idx_r;
  logic                      enq;
  logic                      last;
  logic                      accept;

  // assemble the packet from the incoming word
  always_comb
  begin
    pkt_n.pkt.pad      = '0;
    pkt_n.pkt.data     = in_data_i;
    pkt_n.pkt.hdr.len  = pkt_len;
    pkt_n.pkt.hdr.cord = in_cord_i;
  end

  // one flit leaves per cycle unless the fifo is full
  assign enq    = busy_r & ~out_full_i;
  assign last   = (idx_r == flit_cnt_width'(flit_count - 1));
  // free when idle, or when the last flit goes out this cycle
  assign in_ready_o = ~busy_r | (enq & last);
  assign accept     = in_v_i & in_ready_o;

  assign out_v_o    = busy_r;
  assign out_flit_o = pkt_r.flits[idx_r];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end
    else if (accept)
    begin
      // back to back packets restart at the header
      busy_r <= 1'b1;
      idx_r  <= '0;
    end
    else if (enq)
    begin
      busy_r <= ~last;
      idx_r  <= last ? '0 : idx_r + 1'b1;
    end
  end

  // packet holds still while its flits drain
  always_ff @(posedge clk_i)
  begin
    if (accept)
      pkt_r <= pkt_n;
  end

  // flit index stays inside the packet
  assert property (@(posedge clk_i) disable iff (rst_i)
    idx_r <= flit_cnt_width'(flit_count - 1));

endmodule

/* hw/async_flit_fifo.sv */
`timescale 1ns/1ns
// async flit fifo
// dual clock fifo of eight flits
// gray coded pointers cross through two flop synchronizers
// full and empty are computed from the synchronized copies, so both are conservative

module async_flit_fifo
  (input  logic                               w_clk_i
  ,input  logic                               w_rst_i
  ,input  logic                               w_enq_i
  ,input  logic [wh_link_pkg::flit_width-1:0] w_data_i
  ,output logic                               w_full_o
  ,input  logic                               r_clk_i
  ,input  logic                               r_rst_i
  ,input  logic                               r_deq_i
  ,output logic [wh_link_pkg::flit_width-1:0] r_data_o
  ,output logic                               r_valid_o
  );

  import wh_link_pkg::*;

  // storage written on the write clock only
  logic [flit_width-1:0] mem_r [2**fifo_lg_depth];

  // write side pointers with one extra wrap bit
  logic [fifo_lg_depth:0] w_bin_r;
  logic [fifo_lg_depth:0] w_bin_n;
  logic [fifo_lg_depth:0] w_gray_r;
  logic [fifo_lg_depth:0] w_gray_n;
  logic [fifo_lg_depth:0] r_gray_meta_r;
  logic [fifo_lg_depth:0] r_gray_sync_r;

  // read side pointers
  logic [fifo_lg_depth:0] r_bin_r;
  logic [fifo_lg_depth:0] r_bin_n;
  logic [fifo_lg_depth:0] r_gray_r;
  logic [fifo_lg_depth:0] r_gray_n;
  logic [fifo_lg_depth:0] w_gray_meta_r;
  logic [fifo_lg_depth:0] w_gray_sync_r;

  assign w_bin_n  = w_bin_r + {{fifo_lg_depth{1'b0}}, w_enq_i};
  assign w_gray_n = w_bin_n ^ (w_bin_n >> 1);

  always_ff @(posedge w_clk_i)
  begin
    if (w_rst_i)
    begin
      w_bin_r       <= '0;
      w_gray_r      <= '0;
      r_gray_meta_r <= '0;
      r_gray_sync_r <= '0;
    end
    else
    begin
      w_bin_r       <= w_bin_n;
      w_gray_r      <= w_gray_n;
      // read pointer into the write domain
      r_gray_meta_r <= r_gray_r;
      r_gray_sync_r <= r_gray_meta_r;
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_enq_i)
      mem_r[w_bin_r[fifo_lg_depth-1:0]] <= w_data_i;
  end

  // full when the writer is one lap ahead and the top two gray bits differ
  assign w_full_o = (w_gray_r == {~r_gray_sync_r[fifo_lg_depth -: 2],
                                  r_gray_sync_r[fifo_lg_depth-2:0]});

  assign r_bin_n  = r_bin_r + {{fifo_lg_depth{1'b0}}, r_deq_i};
  assign r_gray_n = r_bin_n ^ (r_bin_n >> 1);

  always_ff @(posedge r_clk_i)
  begin
    if (r_rst_i)
    begin
      r_bin_r       <= '0;
      r_gray_r      <= '0;
      w_gray_meta_r <= '0;
      w_gray_sync_r <= '0;
    end
    else
    begin
      r_bin_r       <= r_bin_n;
      r_gray_r      <= r_gray_n;
      // write pointer into the read domain
      w_gray_meta_r <= w_gray_r;
      w_gray_sync_r <= w_gray_meta_r;
    end
  end

  // not empty once the synchronized write pointer moves past us
  assign r_valid_o = (r_gray_r != w_gray_sync_r);
  assign r_data_o  = mem_r[r_bin_r[fifo_lg_depth-1:0]];

  // callers honor the flags in both domains
  assert property (@(posedge w_clk_i) disable iff (w_rst_i) w_enq_i |-> !w_full_o);
  assert property (@(posedge r_clk_i) disable iff (r_rst_i) r_deq_i |-> r_valid_o);

endmodule

/* hw/flit_deserializer.sv */
`timescale 1ns/1ns
// flit deserializer
// gathers three flits into a wormhole packet and holds its data word
// on the output until the consumer takes it

module flit_deserializer
  (input  logic                                   clk_i
  ,input  logic                                   rst_i
  ,input  logic                                   in_v_i
  ,input  logic [wh_link_pkg::flit_width-1:0]     in_flit_i
  ,output logic                                   in_deq_o
  ,output logic                                   out_v_o
  ,output logic [wh_link_pkg::ral_data_width-1:0] out_data_o
  ,input  logic                                   out_ready_i
  );

  import wh_link_pkg::*;

  wh_pkt_u                   pkt_r;
  logic [flit_cnt_width-1:0] cnt_r;
  logic [flit_cnt_width-1:0] wr_idx;
  logic                      taken;

  // a whole packet is waiting
  assign out_v_o = (cnt_r == flit_cnt_width'(flit_count));
  assign taken   = out_v_o & out_ready_i;

  // keep pulling flits until full
  // on the handshake cycle the next header may already come in
  assign in_deq_o = in_v_i & (~out_v_o | out_ready_i);
  assign wr_idx   = out_v_o ? '0 : cnt_r;

  // header not needed on this side
  assign out_data_o = pkt_r.pkt.data;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cnt_r <= '0;
    else if (taken)
      cnt_r <= in_deq_o ? flit_cnt_width'(1) : '0;
    else if (in_deq_o)
      cnt_r <= cnt_r + 1'b1;
  end

  // flits land in union order
  always_ff @(posedge clk_i)
  begin
    if (in_deq_o)
      pkt_r.flits[wr_idx] <= in_flit_i;
  end

  // offered word stays put until the consumer takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_v_o && !out_ready_i) |=> (out_v_o && $stable(out_data_o)));

endmodule

/* hw/ral_wh_bridge.sv */
`timescale 1ns/1ns
// ral to wormhole bridge
// outbound words become three-flit packets sent across an async fifo
// inbound flits cross back and are reassembled into ral words

module ral_wh_bridge
  (input  logic                               ral_clk_i
  ,input  logic                               wh_clk_i
  ,input  logic                               rst_i
  ,input  wh_link_pkg::ral_link_s             ral_link_i
  ,output wh_link_pkg::ral_link_s             ral_link_o
  ,input  logic                               ral_ready_i
  ,output logic                               ral_ready_o
  ,input  logic [wh_link_pkg::cord_width-1:0] ral_dest_cord_i
  ,input  wh_link_pkg::wh_link_s              wh_link_i
  ,output wh_link_pkg::wh_link_s              wh_link_o
  ,input  logic                               wh_ready_i
  ,output logic                               wh_ready_o
  );

  import wh_link_pkg::*;

  // outbound
  logic                      ser_v;
  logic [flit_width-1:0]     ser_flit;
  logic                      out_full;
  logic                      wh_out_v;
  logic [flit_width-1:0]     wh_out_data;

  // inbound
  logic                      in_full;
  logic                      in_v;
  logic                      in_deq;
  logic [flit_width-1:0]     in_flit;
  logic                      ral_out_v;
  logic [ral_data_width-1:0] ral_out_data;

  flit_serializer i_ser
    (.clk_i(ral_clk_i), .rst_i(rst_i)
    ,.in_v_i(ral_link_i.v), .in_data_i(ral_link_i.data), .in_cord_i(ral_dest_cord_i)
    ,.in_ready_o(ral_ready_o)
    ,.out_v_o(ser_v), .out_flit_o(ser_flit), .out_full_i(out_full)
    );

  // ral clock to wormhole clock
  async_flit_fifo i_ral_to_wh
    (.w_clk_i(ral_clk_i), .w_rst_i(rst_i)
    ,.w_enq_i(ser_v & ~out_full), .w_data_i(ser_flit), .w_full_o(out_full)
    ,.r_clk_i(wh_clk_i), .r_rst_i(rst_i)
    ,.r_deq_i(wh_out_v & wh_ready_i), .r_data_o(wh_out_data), .r_valid_o(wh_out_v)
    );

  assign wh_link_o  = '{v: wh_out_v, data: wh_out_data};
  assign wh_ready_o = ~in_full;

  // wormhole clock to ral clock
  async_flit_fifo i_wh_to_ral
    (.w_clk_i(wh_clk_i), .w_rst_i(rst_i)
    ,.w_enq_i(wh_link_i.v & wh_ready_o), .w_data_i(wh_link_i.data), .w_full_o(in_full)
    ,.r_clk_i(ral_clk_i), .r_rst_i(rst_i)
    ,.r_deq_i(in_deq), .r_data_o(in_flit), .r_valid_o(in_v)
    );

  flit_deserializer i_deser
    (.clk_i(ral_clk_i), .rst_i(rst_i)
    ,.in_v_i(in_v), .in_flit_i(in_flit), .in_deq_o(in_deq)
    ,.out_v_o(ral_out_v), .out_data_o(ral_out_data), .out_ready_i(ral_ready_i)
    );

  assign ral_link_o = '{v: ral_out_v, data: ral_out_data};

endmodule

/* bench/ral_wh_bridge_tb.sv */
`timescale 1ns/1ns
// testbench for the ral to wormhole bridge
// outbound words are checked flit by flit on the wormhole side
// inbound flits are checked as words on the ral side, with a ral stall first

module ral_wh_bridge_tb;

  import wh_link_pkg::*;

  localparam int ral_period  = 40;
  localparam int wh_period   = 30;
  localparam int out_count   = 6;
  localparam int in_count    = 6;
  // fifo depth plus one packet held in the deserializer
  localparam int max_stall_flits = 2**fifo_lg_depth + flit_count;
  localparam int watchdog_ns = (out_count + in_count) * flit_count * 20 * ral_period;

  typedef struct packed {
    logic [cord_width-1:0]     cord;
    logic [ral_data_width-1:0] data;
  } out_entry_s;

  logic                  ral_clk_i;
  logic                  wh_clk_i;
  logic                  rst_i;
  ral_link_s             ral_link_i;
  ral_link_s             ral_link_o;
  logic                  ral_ready_i;
  logic                  ral_ready_o;
  logic [cord_width-1:0] ral_dest_cord_i;
  wh_link_s              wh_link_i;
  wh_link_s              wh_link_o;
  logic                  wh_ready_i;
  logic                  wh_ready_o;

  int flits_seen = 0;
  int words_seen = 0;

  // outbound words with their destinations
  out_entry_s out_tab [out_count] = '{
    '{cord: 6'h00, data: 32'h0000_0000},
    '{cord: 6'h3f, data: 32'hffff_ffff},
    '{cord: 6'h15, data: 32'hdead_beef},
    '{cord: 6'h2a, data: 32'h1234_5678},
    '{cord: 6'h01, data: 32'h8000_0001},
    '{cord: 6'h22, data: 32'h5a5a_a5a5}
  };

  // inbound words, expected back in the same order
  logic [ral_data_width-1:0] in_tab [in_count] = '{
    32'hcafe_f00d, 32'h0000_0001, 32'h7fff_ffff,
    32'h8000_0000, 32'h0f0f_f0f0, 32'h1357_9bdf
  };

  ral_wh_bridge i_dut
    (.ral_clk_i(ral_clk_i), .wh_clk_i(wh_clk_i), .rst_i(rst_i)
    ,.ral_link_i(ral_link_i), .ral_link_o(ral_link_o)
    ,.ral_ready_i(ral_ready_i), .ral_ready_o(ral_ready_o)
    ,.ral_dest_cord_i(ral_dest_cord_i)
    ,.wh_link_i(wh_link_i), .wh_link_o(wh_link_o)
    ,.wh_ready_i(wh_ready_i), .wh_ready_o(wh_ready_o)
    );

  initial ral_clk_i = 1'b0;
  always #(ral_period/2) ral_clk_i = ~ral_clk_i;

  initial wh_clk_i = 1'b0;
  always #(wh_period/2) wh_clk_i = ~wh_clk_i;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_flit(input logic [flit_width-1:0] exp,
                              input logic [flit_width-1:0] got, input string name);
    if (got !== exp)
      stop_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_word(input logic [ral_data_width-1:0] exp,
                              input logic [ral_data_width-1:0] got, input string name);
    if (got !== exp)
      stop_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_flag(input logic exp, input logic got, input string name);
    if (got !== exp)
      stop_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  // header low, then data, zero padding on top; length is flits after the header
  function automatic wh_pkt_u build_packet(input logic [cord_width-1:0] cord,
                                           input logic [ral_data_width-1:0] data);
    wh_pkt_u p;
    p.pkt.pad      = '0;
    p.pkt.data     = data;
    p.pkt.hdr.len  = 3'd2;
    p.pkt.hdr.cord = cord;
    return p;
  endfunction

  // ral producer holds word and cord until taken
  task automatic send_words();
    for (int i = 0; i < out_count; i++)
    begin
      @(negedge ral_clk_i);
      ral_link_i.v    = 1'b1;
      ral_link_i.data = out_tab[3'(i)].data;
      ral_dest_cord_i = out_tab[3'(i)].cord;
      while (!ral_ready_o)
        @(negedge ral_clk_i);
    end
    @(negedge ral_clk_i);
    ral_link_i.v = 1'b0;
  endtask

  // wormhole consumer with random ready
  task automatic take_flits();
    wh_pkt_u    exp_pkt;
    logic [1:0] fidx;
    while (flits_seen < out_count * flit_count)
    begin
      @(negedge wh_clk_i);
      wh_ready_i = ($urandom % 4) != 0;
      if (wh_link_o.v && wh_ready_i)
      begin
        exp_pkt = build_packet(out_tab[3'(flits_seen / flit_count)].cord,
                               out_tab[3'(flits_seen / flit_count)].data);
        fidx = 2'(flits_seen % flit_count);
        compare_flit(exp_pkt.flits[fidx], wh_link_o.data, "wh_link_o.data");
        flits_seen++;
      end
    end
    // no fourth flit may follow
    wh_ready_i = 1'b1;
    repeat (20)
    begin
      @(negedge wh_clk_i);
      compare_flag(1'b0, wh_link_o.v, "wh_link_o.v");
    end
    wh_ready_i = 1'b0;
  endtask

  // wormhole producer that counts flits taken before the first push back
  task automatic send_flits();
    wh_pkt_u    pkt;
    logic [1:0] fidx;
    int         sent;
    logic       seen_low;
    sent     = 0;
    seen_low = 1'b0;
    while (sent < in_count * flit_count)
    begin
      @(negedge wh_clk_i);
      pkt  = build_packet(6'(sent / flit_count + 1), in_tab[3'(sent / flit_count)]);
      fidx = 2'(sent % flit_count);
      wh_link_i.v    = 1'b1;
      wh_link_i.data = pkt.flits[fidx];
      if (!wh_ready_o)
        seen_low = 1'b1;
      else
      begin
        sent++;
        if (!seen_low && sent > max_stall_flits)
          stop_run("wormhole side kept accepting flits while the ral side was stalled");
      end
    end
    @(negedge wh_clk_i);
    wh_link_i.v = 1'b0;
  endtask

  // ral consumer stalled until the wormhole side is pushed back
  task automatic take_words();
    logic                      hold;
    logic                      pend;
    logic [ral_data_width-1:0] last_data;
    hold      = 1'b1;
    pend      = 1'b0;
    last_data = '0;
    while (words_seen < in_count)
    begin
      @(negedge ral_clk_i);
      // offered word must not move before it is taken
      if (pend)
      begin
        compare_flag(1'b1, ral_link_o.v, "ral_link_o.v");
        compare_word(last_data, ral_link_o.data, "ral_link_o.data");
      end
      if (hold && !wh_ready_o)
        hold = 1'b0;
      ral_ready_i = hold ? 1'b0 : (($urandom % 3) != 0);
      if (ral_link_o.v && ral_ready_i)
      begin
        compare_word(in_tab[3'(words_seen)], ral_link_o.data, "ral_link_o.data");
        words_seen++;
        pend = 1'b0;
      end
      else
      begin
        pend      = ral_link_o.v;
        last_data = ral_link_o.data;
      end
    end
    @(negedge ral_clk_i);
    ral_ready_i = 1'b0;
  endtask

  initial
  begin
    #(watchdog_ns);
    stop_run("timeout, the bridge stopped delivering flits or words");
  end

  initial
  begin
    void'($urandom(32'h131c623f));
    rst_i           = 1'b1;
    ral_link_i      = '0;
    ral_ready_i     = 1'b0;
    ral_dest_cord_i = '0;
    wh_link_i       = '0;
    wh_ready_i      = 1'b0;
    repeat (3) @(posedge ral_clk_i);
    @(negedge ral_clk_i);
    rst_i = 1'b0;
    @(negedge ral_clk_i);
    // idle after reset
    compare_flag(1'b0, ral_link_o.v, "ral_link_o.v");
    compare_flag(1'b0, wh_link_o.v, "wh_link_o.v");
    compare_flag(1'b1, ral_ready_o, "ral_ready_o");
    compare_flag(1'b1, wh_ready_o, "wh_ready_o");
    fork
      send_words();
      take_flits();
    join
    fork
      send_flits();
      take_words();
    join
    if (flits_seen == out_count * flit_count && words_seen == in_count)
    begin
      $display("All tests passed");
      $finish;
    end
    else
      stop_run("not every flit or word arrived");
  end

endmodule

/* src.f */
hw/wh_link_pkg.sv
hw/flit_serializer.sv
hw/async_flit_fifo.sv
hw/flit_deserializer.sv
hw/ral_wh_bridge.sv
bench/ral_wh_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ral to wormhole bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir
bin=ral_wh_bridge_sim

verilator --binary --timing --assert -f src.f --top-module ral_wh_bridge_tb \
  --Mdir "$obj" -o "$bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$obj/$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" "$log"; then
  echo "simulation PASS"
  exit 0
fi
echo "simulation FAIL"
exit 1
